/* build.f */
+incdir+include
hw/gb80_irq_pkg.sv
hw/gb80_reg_pkg.sv
hw/irq_priority.sv
hw/irq_controller.sv
hw/reg_num_decode.sv
hw/field_decode_pipe.sv
hw/gb80_ctrl.sv
verification/gb80_ctrl_sva.sv
verification/gb80_ctrl_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module gb80_ctrl_tb

sim:
	verilator --binary --timing --assert -f build.f --top-module gb80_ctrl_tb -Mdir obj_dir
	./obj_dir/Vgb80_ctrl_tb +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* verification/gb80_ctrl_tb.sv */
`timescale 1ns/1ps

module gb80_ctrl_tb
   import gb80_irq_pkg::*, gb80_reg_pkg::*;
();

   // Stimulus length plus room for reset and the final drain
   localparam int STIM_CYCLES = 400;
   localparam int CYCLE_LIMIT = STIM_CYCLES + 200;

   logic        clock = 1'b0;
   logic        reset = 1'b1;
   logic        if_we = 1'b0;
   irq_bits_t   if_wdata = '0;
   logic        ie_we = 1'b0;
   irq_bits_t   ie_wdata = '0;
   logic        ime_set = 1'b0;
   logic        ime_clear = 1'b0;
   irq_bits_t   if_data;
   irq_bits_t   ie_data;
   logic        ime;
   logic        irq_valid;
   irq_vector_t irq_vector;
   logic        irq_ready = 1'b0;
   logic        in_valid = 1'b0;
   nin_code_t   in_rn = '0;
   rn_mode_t    in_mode = RN_BYTE;
   rf_index_t   in_override = RF_NONE;
   cond_t       in_cond = '0;
   flags_t      in_flags = '0;
   logic        in_ready;
   logic        out_valid;
   rf_index_t   out_reg;
   logic        out_taken;
   logic        out_ready = 1'b0;

   int seed = 90;
   int cycle_count = 0;

   gb80_ctrl dut_i (.*);

   bind gb80_ctrl gb80_ctrl_sva sva_i (.*);

   always #20 clock = ~clock;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("** FAIL **");
         $fatal(1, "Simulation stopped on timeout");
      end
   end

   // Stop at the first assertion failure
   always @(negedge clock) begin
      if (dut_i.sva_i.error_count != 0) begin
         $display("** FAIL **");
         $fatal(1, "Assertion check failed");
      end
   end

   task automatic drive_cycle();
      logic [31:0] r;
      logic [31:0] pick;
      @(posedge clock);
      r    = $random(seed);
      pick = $unsigned($random(seed)) % 12;
      // Host writes are rare so pending interrupts get serviced
      if_we     <= (r[2:0] == 3'd0);
      if_wdata  <= irq_bits_t'($random(seed));
      ie_we     <= (r[11:9] == 3'd0);
      ie_wdata  <= irq_bits_t'($random(seed));
      ime_set   <= (r[5:3] != 3'd0);
      ime_clear <= (r[7:6] == 2'd0);
      irq_ready <= r[8];
      // Field stream with random stalls on both sides
      in_valid  <= r[12] | r[13];
      out_ready <= r[14];
      in_mode   <= rn_mode_t'(r[16:15]);
      in_rn     <= r[22:20];
      in_cond   <= r[24:23];
      in_flags  <= r[28:25];
      if (r[19:17] == 3'd0) begin
         in_override <= rf_index_t'(pick);
      end else begin
         in_override <= RF_NONE;
      end
   endtask

   task automatic drain_stream();
      @(posedge clock);
      if_we     <= 1'b0;
      ie_we     <= 1'b0;
      ime_set   <= 1'b0;
      ime_clear <= 1'b0;
      irq_ready <= 1'b1;
      in_valid  <= 1'b0;
      out_ready <= 1'b1;
      @(negedge clock);
      while (out_valid) begin
         @(negedge clock);
      end
   endtask

   initial begin
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      repeat (STIM_CYCLES) begin
         drive_cycle();
      end
      drain_stream();
      repeat (2) @(posedge clock);
      if (dut_i.sva_i.error_count == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("** FAIL **");
         $fatal(1, "Assertion checks failed during the run");
      end
   end

endmodule

/* verification/gb80_ctrl_sva.sv */
`timescale 1ns/1ps

`include "gb80_consts.svh"

module gb80_ctrl_sva
   import gb80_irq_pkg::*, gb80_reg_pkg::*;
(
   input logic        clock,
   input logic        reset,
   input logic        if_we,
   input irq_bits_t   if_wdata,
   input logic        ie_we,
   input irq_bits_t   ie_wdata,
   input logic        ime_set,
   input logic        ime_clear,
   input irq_bits_t   if_data,
   input irq_bits_t   ie_data,
   input logic        ime,
   input logic        irq_valid,
   input irq_vector_t irq_vector,
   input logic        irq_ready,
   input logic        in_valid,
   input nin_code_t   in_rn,
   input rn_mode_t    in_mode,
   input rf_index_t   in_override,
   input cond_t       in_cond,
   input flags_t      in_flags,
   input logic        in_ready,
   input logic        out_valid,
   input logic        out_ready,
   input rf_index_t   out_reg,
   input logic        out_taken
);

   int unsigned error_count = 0;

   logic      took_q;
   logic      accepted_q;
   irq_bits_t if_expect_q;
   irq_bits_t ie_expect_q;
   logic      ime_expect_q;
   rf_index_t reg_expect_q;
   logic      taken_expect_q;

   // Source 0 has the highest priority, so search upward from it
   function automatic int lowest_source(irq_bits_t bits);
      int n;
      n = 0;
      while (n < `GB80_IRQ_COUNT - 1 && !bits[n]) begin
         n++;
      end
      return n;
   endfunction

   function automatic irq_vector_t expected_vector(irq_bits_t bits);
      return irq_vector_t'(`GB80_IRQ_VEC_BASE + 8 * lowest_source(bits));
   endfunction

   function automatic rf_index_t expected_reg(rf_index_t ovr, nin_code_t rn, rn_mode_t mode);
      rf_index_t byte_regs [8];
      rf_index_t pair_full [4];
      rf_index_t pair_hi [4];
      rf_index_t pair_lo [4];
      rf_index_t r;
      // Codes 6 and 7 are unlisted and fall back to B
      byte_regs = '{RF_B, RF_C, RF_D, RF_E, RF_H, RF_L, RF_B, RF_B};
      pair_full = '{RF_BC, RF_DE, RF_HL, RF_SP};
      pair_hi   = '{RF_B, RF_D, RF_H, RF_SPH};
      pair_lo   = '{RF_C, RF_E, RF_L, RF_SPL};
      r = RF_B;
      if (ovr != RF_NONE) begin
         r = ovr;
      end else if (mode == RN_BYTE) begin
         r = byte_regs[rn];
      end else if (rn <= 3'd3) begin
         case (mode)
            RN_PAIR:    r = pair_full[rn[1:0]];
            RN_PAIR_HI: r = pair_hi[rn[1:0]];
            default:    r = pair_lo[rn[1:0]];
         endcase
      end
      return r;
   endfunction

   // Code bit 1 picks C over Z, bit 0 says the flag must be set
   function automatic logic expected_taken(cond_t c, flags_t f);
      logic flag;
      flag = c[1] ? f[`GB80_F_C] : f[`GB80_F_Z];
      return flag == c[0];
   endfunction

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         took_q     <= 1'b0;
         accepted_q <= 1'b0;
      end else begin
         took_q     <= irq_valid && irq_ready;
         accepted_q <= in_valid && in_ready;
      end
   end

   // Expected register state after this edge, and the item entering the stage
   always_ff @(posedge clock) begin
      if (if_we) begin
         if_expect_q <= if_wdata;
      end else if (irq_valid && irq_ready) begin
         if_expect_q <= if_data & ~(irq_bits_t'(1) << lowest_source(if_data & ie_data));
      end else begin
         if_expect_q <= if_data;
      end
      ie_expect_q <= ie_we ? ie_wdata : ie_data;
      // A completed transfer masks interrupts even against a set
      if (irq_valid && irq_ready) begin
         ime_expect_q <= 1'b0;
      end else if (ime_set) begin
         ime_expect_q <= 1'b1;
      end else if (ime_clear) begin
         ime_expect_q <= 1'b0;
      end else begin
         ime_expect_q <= ime;
      end
      reg_expect_q   <= expected_reg(in_override, in_rn, in_mode);
      taken_expect_q <= expected_taken(in_cond, in_flags);
   end

   vector_lowest: assert property (@(posedge clock) disable iff (reset)
      ime && (if_data & ie_data) != '0 |-> irq_vector == expected_vector(if_data & ie_data))
   else begin
      $error("MISMATCH at %0t: irq_vector %h for IF %b IE %b", $time, irq_vector,
             if_data, ie_data);
      error_count++;
   end

   valid_gated: assert property (@(posedge clock) disable iff (reset)
      irq_valid == (ime && (if_data & ie_data) != '0))
   else begin
      $error("MISMATCH at %0t: irq_valid %b with IME %b IF %b IE %b", $time, irq_valid,
             ime, if_data, ie_data);
      error_count++;
   end

   host_regs: assert property (@(posedge clock) disable iff (reset)
      if_data == if_expect_q && ie_data == ie_expect_q && ime == ime_expect_q)
   else begin
      $error("MISMATCH at %0t: IF %b IE %b IME %b, expected %b %b %b", $time, if_data,
             ie_data, ime, if_expect_q, ie_expect_q, ime_expect_q);
      error_count++;
   end

   service_clear: assert property (@(posedge clock) disable iff (reset)
      took_q |-> !ime && if_data == if_expect_q)
   else begin
      $error("MISMATCH at %0t: after service IME %b IF %b, IF expected %b", $time, ime,
             if_data, if_expect_q);
      error_count++;
   end

   stage_ready: assert property (@(posedge clock) disable iff (reset)
      in_ready == (!out_valid || out_ready))
   else begin
      $error("MISMATCH at %0t: in_ready %b with out_valid %b out_ready %b", $time,
             in_ready, out_valid, out_ready);
      error_count++;
   end

   // Nothing offered while the stage drains leaves it empty
   stage_empty: assert property (@(posedge clock) disable iff (reset)
      in_ready && !in_valid |=> !out_valid)
   else begin
      $error("MISMATCH at %0t: out_valid high with no item accepted", $time);
      error_count++;
   end

   decode_index: assert property (@(posedge clock) disable iff (reset)
      accepted_q |-> out_valid && out_reg == reg_expect_q)
   else begin
      $error("MISMATCH at %0t: out_reg %0d, expected %0d", $time, out_reg, reg_expect_q);
      error_count++;
   end

   branch_taken: assert property (@(posedge clock) disable iff (reset)
      accepted_q |-> out_taken == taken_expect_q)
   else begin
      $error("MISMATCH at %0t: out_taken %b, expected %b", $time, out_taken, taken_expect_q);
      error_count++;
   end

   output_hold: assert property (@(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_reg) && $stable(out_taken))
   else begin
      $error("MISMATCH at %0t: output changed while stalled", $time);
      error_count++;
   end

endmodule

/* hw/gb80_ctrl.sv */
`timescale 1ns/1ps

module gb80_ctrl
   import gb80_irq_pkg::*, gb80_reg_pkg::*;
(
   input  logic        clock,
   input  logic        reset,

   // Host side of IF, IE and IME
   input  logic        if_we,
   input  irq_bits_t   if_wdata,
   input  logic        ie_we,
   input  irq_bits_t   ie_wdata,
   input  logic        ime_set,
   input  logic        ime_clear,
   output irq_bits_t   if_data,
   output irq_bits_t   ie_data,
   output logic        ime,

   // Vector towards the core
   output logic        irq_valid,
   output irq_vector_t irq_vector,
   input  logic        irq_ready,

   // Operand field stream
   input  logic        in_valid,
   input  nin_code_t   in_rn,
   input  rn_mode_t    in_mode,
   input  rf_index_t   in_override,
   input  cond_t       in_cond,
   input  flags_t      in_flags,
   output logic        in_ready,
   output logic        out_valid,
   output rf_index_t   out_reg,
   output logic        out_taken,
   input  logic        out_ready
);

   irq_controller irq_i (
      .clock      (clock),
      .reset      (reset),
      .if_we      (if_we),
      .if_wdata   (if_wdata),
      .ie_we      (ie_we),
      .ie_wdata   (ie_wdata),
      .ime_set    (ime_set),
      .ime_clear  (ime_clear),
      .irq_ready  (irq_ready),
      .irq_valid  (irq_valid),
      .irq_vector (irq_vector),
      .if_data    (if_data),
      .ie_data    (ie_data),
      .ime        (ime)
   );

   field_decode_pipe field_i (
      .clock       (clock),
      .reset       (reset),
      .in_valid    (in_valid),
      .in_rn       (in_rn),
      .in_mode     (in_mode),
      .in_override (in_override),
      .in_cond     (in_cond),
      .in_flags    (in_flags),
      .out_ready   (out_ready),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_reg     (out_reg),
      .out_taken   (out_taken)
   );

endmodule

/* hw/field_decode_pipe.sv */
`timescale 1ns/1ps

`include "gb80_consts.svh"

module field_decode_pipe
   import gb80_reg_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      in_valid,
   input  nin_code_t in_rn,
   input  rn_mode_t  in_mode,
   input  rf_index_t in_override,
   input  cond_t     in_cond,
   input  flags_t    in_flags,
   input  logic      out_ready,
   output logic      in_ready,
   output logic      out_valid,
   output rf_index_t out_reg,
   output logic      out_taken
);

   rf_index_t dec_reg;
   logic      taken;
   logic      load;

   logic      valid_q;
   rf_index_t reg_q;
   logic      taken_q;

   reg_num_decode rn_dec_i (
      .override (in_override),
      .rn       (in_rn),
      .mode     (in_mode),
      .index    (dec_reg)
   );

   // Branch condition against Z and C
   always_comb begin
      case (in_cond)
         COND_NZ: taken = ~in_flags[`GB80_F_Z];
         COND_Z:  taken = in_flags[`GB80_F_Z];
         COND_NC: taken = ~in_flags[`GB80_F_C];
         COND_C:  taken = in_flags[`GB80_F_C];
         default: taken = 1'b0;
      endcase
   end

   // Stage is free when empty or when its item leaves this cycle
   assign in_ready = ~valid_q | out_ready;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clock) begin
      if (load) begin
         reg_q   <= dec_reg;
         taken_q <= taken;
      end
   end

   assign out_valid = valid_q;
   assign out_reg   = reg_q;
   assign out_taken = taken_q;

endmodule

/* hw/reg_num_decode.sv */
`timescale 1ns/1ps

module reg_num_decode
   import gb80_reg_pkg::*;
(
   input  rf_index_t override,
   input  nin_code_t rn,
   input  rn_mode_t  mode,
   output rf_index_t index
);

   always_comb begin
      index = RF_B;
      if (override != RF_NONE) begin
         index = override;
      end else begin
         case (mode)
            RN_BYTE: begin
               case (rn)
                  NIN_B:   index = RF_B;
                  NIN_C:   index = RF_C;
                  NIN_D:   index = RF_D;
                  NIN_E:   index = RF_E;
                  NIN_H:   index = RF_H;
                  NIN_L:   index = RF_L;
                  default: index = RF_B;
               endcase
            end
            RN_PAIR: begin
               case (rn)
                  NIN_BC:  index = RF_BC;
                  NIN_DE:  index = RF_DE;
                  NIN_HL:  index = RF_HL;
                  NIN_SP:  index = RF_SP;
                  default: index = RF_B;
               endcase
            end
            // Upper byte of the pair
            RN_PAIR_HI: begin
               case (rn)
                  NIN_BC:  index = RF_B;
                  NIN_DE:  index = RF_D;
                  NIN_HL:  index = RF_H;
                  NIN_SP:  index = RF_SPH;
                  default: index = RF_B;
               endcase
            end
            // Lower byte of the pair
            RN_PAIR_LO: begin
               case (rn)
                  NIN_BC:  index = RF_C;
                  NIN_DE:  index = RF_E;
                  NIN_HL:  index = RF_L;
                  NIN_SP:  index = RF_SPL;
                  default: index = RF_B;
               endcase
            end
            default: index = RF_B;
         endcase
      end
   end

endmodule

/* hw/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller
   import gb80_irq_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic        if_we,
   input  irq_bits_t   if_wdata,
   input  logic        ie_we,
   input  irq_bits_t   ie_wdata,
   input  logic        ime_set,
   input  logic        ime_clear,
   input  logic        irq_ready,
   output logic        irq_valid,
   output irq_vector_t irq_vector,
   output irq_bits_t   if_data,
   output irq_bits_t   ie_data,
   output logic        ime
);

   irq_bits_t if_q;
   irq_bits_t ie_q;
   logic      ime_q;

   irq_bits_t pending;
   irq_bits_t sel_mask;
   logic      any;
   logic      take;

   // Requested and enabled
   assign pending = if_q & ie_q;

   irq_priority prio_i (
      .pending  (pending),
      .any      (any),
      .sel_mask (sel_mask),
      .vector   (irq_vector)
   );

   // Straight from the registers, so valid and vector hold under back-pressure
   assign irq_valid = ime_q & any;
   assign take      = irq_valid & irq_ready;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
      end else if (if_we) begin
         // Host write beats the service clear
         if_q <= if_wdata;
      end else if (take) begin
         if_q <= if_q & sel_mask;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_q <= '0;
      end else if (ie_we) begin
         ie_q <= ie_wdata;
      end
   end

   // Entering a handler always masks further interrupts
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ime_q <= 1'b0;
      end else if (take) begin
         ime_q <= 1'b0;
      end else if (ime_set) begin
         ime_q <= 1'b1;
      end else if (ime_clear) begin
         ime_q <= 1'b0;
      end
   end

   assign if_data = if_q;
   assign ie_data = ie_q;
   assign ime     = ime_q;

endmodule

/* hw/irq_priority.sv */
`timescale 1ns/1ps

`include "gb80_consts.svh"

module irq_priority
   import gb80_irq_pkg::*;
(
   input  irq_bits_t   pending,
   output logic        any,
   output irq_bits_t   sel_mask,
   output irq_vector_t vector
);

   irq_sel_t sel;

   assign any = |pending;

   // Walk from the top down so the lowest set bit is the last to hit
   always_comb begin
      sel      = '0;
      sel_mask = IRQ_KEEP_ALL;
      for (int i = `GB80_IRQ_COUNT - 1; i >= 0; i--) begin
         if (pending[i]) begin
            sel      = irq_sel_t'(i);
            sel_mask = ~(irq_bits_t'(1) << i);
         end
      end
   end

   // Base plus 8 times the source number
   assign vector = `GB80_IRQ_VEC_BASE
                   + (irq_vector_t'(sel) << `GB80_IRQ_VEC_SHIFT);

endmodule

/* hw/gb80_reg_pkg.sv */
`include "gb80_consts.svh"

package gb80_reg_pkg;

   // Z N H C, the upper nibble of register F
   typedef logic [3:0] flags_t;

   // Register number as it appears in the opcode
   typedef logic [2:0] nin_code_t;

   // 8-bit register codes
   localparam nin_code_t NIN_B = 3'd0;
   localparam nin_code_t NIN_C = 3'd1;
   localparam nin_code_t NIN_D = 3'd2;
   localparam nin_code_t NIN_E = 3'd3;
   localparam nin_code_t NIN_H = 3'd4;
   localparam nin_code_t NIN_L = 3'd5;

   // Register pair codes
   localparam nin_code_t NIN_BC = 3'd0;
   localparam nin_code_t NIN_DE = 3'd1;
   localparam nin_code_t NIN_HL = 3'd2;
   localparam nin_code_t NIN_SP = 3'd3;

   // Register file index, halves first, then the 16-bit pairs
   typedef enum logic [4:0] {
      RF_B    = 5'd0,
      RF_C    = 5'd1,
      RF_D    = 5'd2,
      RF_E    = 5'd3,
      RF_H    = 5'd4,
      RF_L    = 5'd5,
      RF_SPH  = 5'd6,
      RF_SPL  = 5'd7,
      RF_BC   = 5'd8,
      RF_DE   = 5'd9,
      RF_HL   = 5'd10,
      RF_SP   = 5'd11,
      RF_NONE = 5'd31
   } rf_index_t;

   // How the opcode register field is read
   typedef enum logic [1:0] {
      RN_BYTE    = 2'd0,
      RN_PAIR    = 2'd1,
      RN_PAIR_HI = 2'd2,
      RN_PAIR_LO = 2'd3
   } rn_mode_t;

   // Branch condition, opcode bits 4:3
   typedef logic [1:0] cond_t;

   localparam cond_t COND_NZ = 2'd0;
   localparam cond_t COND_Z  = 2'd1;
   localparam cond_t COND_NC = 2'd2;
   localparam cond_t COND_C  = 2'd3;

endpackage

/* hw/gb80_irq_pkg.sv */
`include "gb80_consts.svh"

package gb80_irq_pkg;

   // One bit per source, bit 0 has the highest priority
   typedef logic [`GB80_IRQ_COUNT-1:0] irq_bits_t;

   // Number of the selected source
   typedef logic [2:0] irq_sel_t;

   // Low byte of the jump address
   typedef logic [7:0] irq_vector_t;

   // Mask that keeps every IF bit
   localparam irq_bits_t IRQ_KEEP_ALL = '1;

endpackage

/* include/gb80_consts.svh */
`ifndef GB80_CONSTS_SVH
`define GB80_CONSTS_SVH

// Bit positions inside the Z N H C flags nibble
`define GB80_F_Z 3
`define GB80_F_N 2
`define GB80_F_H 1
`define GB80_F_C 0

// Interrupt sources: VBlank, LCD STAT, timer, serial, joypad
`define GB80_IRQ_COUNT 5

// Jump target of source 0; every next source sits 8 bytes higher
`define GB80_IRQ_VEC_BASE 8'h40

// Spacing between two interrupt vectors, as a shift
`define GB80_IRQ_VEC_SHIFT 3

`endif
